/* Makefile */
# Verilator build and run of the console I/O controller testbench.

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --assert -Wno-fatal --top-module tb_md_io -f flist.f -Mdir obj_dir
	./obj_dir/Vtb_md_io | tee $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* flist.f */
+incdir+include
hw/io_pkg.sv
hw/port_bus_if.sv
hw/io_baud_gen.sv
hw/io_bus.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/ctrl_port.sv
hw/md_io.sv
sim/io_checker.sv
sim/tb_md_io.sv

/* hw/ctrl_port.sv */
`timescale 1ns/100ps
`default_nettype none

module ctrl_port
(
	input  wire logic                MCLK,
	input  wire logic                reset_i,
	input  wire logic [6:0]          pins_i,
	input  wire io_pkg::baud_ticks_t ticks_i,
	output logic      [6:0]          pins_o,
	output logic      [6:0]          dir_o,
	output logic                     irq_o,
	port_bus_if.port                 bus
);
	import io_pkg::*;

	logic [7:0] pdata_q;
	logic [7:0] pctrl_q;
	logic [7:0] tx_hold_q;
	logic [4:0] sctrl_q; // only the upper five bits are writable.
	sctrl_u     status;
	logic       tick;
	logic       tx_line;
	logic       tx_full;
	logic       rx_ready;
	logic       rx_error;
	logic [7:0] rx_data;

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			pdata_q <= 8'h00;
			pctrl_q <= 8'h00;
			tx_hold_q <= 8'h00;
			sctrl_q <= 5'b00000;
		end
		else
		begin
			if (bus.wr_data)
				pdata_q <= bus.wdata;
			if (bus.wr_ctrl)
				pctrl_q <= bus.wdata;
			if (bus.wr_tx)
				tx_hold_q <= bus.wdata;
			if (bus.wr_sctrl)
				sctrl_q <= bus.wdata[7:3];
		end
	end

	assign status.raw = {sctrl_q, rx_error, rx_ready, tx_full};
	assign tick = ticks_i[status.f.baud_sel];

	// serial mode takes over pin 4 for transmit and pin 5 for receive.
	always_comb
	begin
		dir_o = pctrl_q[6:0];
		pins_o = pdata_q[6:0];
		if (status.f.tx_en)
		begin
			dir_o[4] = 1'b1;
			pins_o[4] = tx_line;
		end
		if (status.f.rx_en)
			dir_o[5] = 1'b0;
	end

	assign irq_o = (pctrl_q[7] & ~pins_i[6]) | (rx_ready & status.f.rx_irq_en); // TH is pin 6.

	assign bus.pdata = pdata_q;
	assign bus.pctrl = pctrl_q;
	assign bus.tx_hold = tx_hold_q;
	assign bus.rx_data = rx_data;
	assign bus.sctrl_status = status;

	uart_tx uart_tx_inst
	(
		.MCLK     (MCLK),
		.reset_i  (reset_i),
		.tick_i   (tick),
		.enable_i (status.f.tx_en),
		.load_i   (bus.wr_tx),
		.data_i   (bus.wdata),
		.line_o   (tx_line),
		.full_o   (tx_full)
	);

	uart_rx uart_rx_inst
	(
		.MCLK     (MCLK),
		.reset_i  (reset_i),
		.tick_i   (tick),
		.enable_i (status.f.rx_en),
		.line_i   (pins_i[5]),
		.clear_i  (bus.rd_rx),
		.data_o   (rx_data),
		.ready_o  (rx_ready),
		.error_o  (rx_error)
	);

endmodule

`default_nettype wire

/* hw/io_baud_gen.sv */
`timescale 1ns/100ps
`default_nettype none

`include "io_macros.svh"

module io_baud_gen
(
	input  wire logic          MCLK,
	input  wire logic          reset_i,
	output io_pkg::baud_ticks_t ticks_o
);

	localparam int BASE_LOG = $clog2(`BAUD_BASE_DIV);
	localparam int CNT_W = BASE_LOG + 3;

	logic [CNT_W-1:0] cnt_q;

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
			cnt_q <= '0;
		else
			cnt_q <= cnt_q + 1'b1;
	end

	// each slower rate halves the one below it.
	for (genvar n = 0; n < 4; n++)
	begin : g_tick
		localparam int PERIOD = `BAUD_BASE_DIV << n;

		assign ticks_o[n] = &cnt_q[BASE_LOG+n-1:0];

		a_tick_period: assert property (@(posedge MCLK) disable iff (reset_i)
			ticks_o[n] |=> !ticks_o[n] [*(PERIOD-1)] ##1 ticks_o[n]);
	end

endmodule

`default_nettype wire

/* hw/io_bus.sv */
`timescale 1ns/100ps
`default_nettype none

`include "io_macros.svh"

module io_bus
(
	input  wire logic       MCLK,
	input  wire logic       reset_i,
	input  wire logic       wr_i,
	input  wire logic       rd_i,
	input  wire logic [3:0] addr_i,
	input  wire logic [7:0] wdata_i,
	input  wire logic       ntsc_i,
	input  wire logic       disk_i,
	input  wire logic       jap_i,
	input  wire logic [6:0] port_pins_i [3],
	output logic      [7:0] rdata_o,
	port_bus_if.bus         pa,
	port_bus_if.bus         pb,
	port_bus_if.bus         pc
);
	import io_pkg::*;

	localparam logic [2:0] K_NONE  = 3'd0;
	localparam logic [2:0] K_VER   = 3'd1;
	localparam logic [2:0] K_DATA  = 3'd2;
	localparam logic [2:0] K_CTRL  = 3'd3;
	localparam logic [2:0] K_TX    = 3'd4;
	localparam logic [2:0] K_RX    = 3'd5;
	localparam logic [2:0] K_SCTRL = 3'd6;

	port_idx_t  sel_port;
	logic [2:0] sel_kind;
	logic [4:0] kind_stb;
	logic [4:0] stb [3]; // wr_data, wr_ctrl, wr_tx, wr_sctrl, rd_rx.
	logic [7:0] version_byte;
	logic [7:0] rd_next;
	logic [7:0] pdata [3];
	logic [7:0] pctrl [3];
	logic [7:0] tx_hold [3];
	logic [7:0] rx_data [3];
	logic [7:0] status [3];

	assign pdata = '{pa.pdata, pb.pdata, pc.pdata};
	assign pctrl = '{pa.pctrl, pb.pctrl, pc.pctrl};
	assign tx_hold = '{pa.tx_hold, pb.tx_hold, pc.tx_hold};
	assign rx_data = '{pa.rx_data, pb.rx_data, pc.rx_data};
	assign status = '{pa.sctrl_status, pb.sctrl_status, pc.sctrl_status};

	assign version_byte = {jap_i, ~ntsc_i, disk_i, 5'b00000};

	// parallel registers step by one per port, serial registers by three.
	always_comb
	begin
		sel_port = '0;
		sel_kind = (addr_i == `IO_ADDR_VERSION) ? K_VER : K_NONE;
		for (int p = 0; p < 3; p++)
		begin
			if (addr_i == `IO_ADDR_DATA_A + 4'(p))
			begin
				sel_port = port_idx_t'(p);
				sel_kind = K_DATA;
			end
			if (addr_i == `IO_ADDR_CTRL_A + 4'(p))
			begin
				sel_port = port_idx_t'(p);
				sel_kind = K_CTRL;
			end
			if (addr_i == `IO_ADDR_TX_A + 4'(3 * p))
			begin
				sel_port = port_idx_t'(p);
				sel_kind = K_TX;
			end
			if (addr_i == `IO_ADDR_RX_A + 4'(3 * p))
			begin
				sel_port = port_idx_t'(p);
				sel_kind = K_RX;
			end
			if (addr_i == `IO_ADDR_SCTRL_A + 4'(3 * p))
			begin
				sel_port = port_idx_t'(p);
				sel_kind = K_SCTRL;
			end
		end
	end

	assign kind_stb = {wr_i & (sel_kind == K_DATA), wr_i & (sel_kind == K_CTRL),
		wr_i & (sel_kind == K_TX), wr_i & (sel_kind == K_SCTRL), rd_i & (sel_kind == K_RX)};

	always_comb
	begin
		for (int p = 0; p < 3; p++)
			stb[p] = kind_stb & {5{sel_port == port_idx_t'(p)}};
	end

	assign {pa.wr_data, pa.wr_ctrl, pa.wr_tx, pa.wr_sctrl, pa.rd_rx} = stb[0];
	assign {pb.wr_data, pb.wr_ctrl, pb.wr_tx, pb.wr_sctrl, pb.rd_rx} = stb[1];
	assign {pc.wr_data, pc.wr_ctrl, pc.wr_tx, pc.wr_sctrl, pc.rd_rx} = stb[2];
	assign pa.wdata = wdata_i;
	assign pb.wdata = wdata_i;
	assign pc.wdata = wdata_i;

	always_comb
	begin
		case (sel_kind)
			K_VER:   rd_next = version_byte;
			K_DATA:  rd_next = {pdata[sel_port][7], port_pins_i[sel_port]}; // pins read live.
			K_CTRL:  rd_next = pctrl[sel_port];
			K_TX:    rd_next = tx_hold[sel_port];
			K_RX:    rd_next = rx_data[sel_port];
			K_SCTRL: rd_next = status[sel_port];
			default: rd_next = 8'h00;
		endcase
	end

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
			rdata_o <= 8'h00;
		else if (rd_i)
			rdata_o <= rd_next;
	end

endmodule

`default_nettype wire

/* hw/io_pkg.sv */
`default_nettype none

package io_pkg;

	typedef logic [1:0] port_idx_t; // ports A, B and C are 0, 1 and 2.

	typedef logic [3:0] baud_ticks_t;

	// serial control byte as written, and as read back with the status bits.
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [1:0] baud_sel;
			logic       rx_en;
			logic       tx_en;
			logic       rx_irq_en;
			logic       rx_error;
			logic       rx_ready;
			logic       tx_full;
		} f;
	} sctrl_u;

endpackage

`default_nettype wire

/* hw/md_io.sv */
`timescale 1ns/100ps
`default_nettype none

module md_io
(
	input  wire logic       MCLK,
	input  wire logic       reset_i,
	input  wire logic       wr_i,
	input  wire logic       rd_i,
	input  wire logic [3:0] addr_i,
	input  wire logic [7:0] wdata_i,
	output logic      [7:0] rdata_o,
	input  wire logic       ntsc_i,
	input  wire logic       disk_i,
	input  wire logic       jap_i,
	input  wire logic [6:0] port_a_i,
	output logic      [6:0] port_a_o,
	output logic      [6:0] port_a_dir_o,
	input  wire logic [6:0] port_b_i,
	output logic      [6:0] port_b_o,
	output logic      [6:0] port_b_dir_o,
	input  wire logic [6:0] port_c_i,
	output logic      [6:0] port_c_o,
	output logic      [6:0] port_c_dir_o,
	output logic            hl_o
);
	import io_pkg::*;

	baud_ticks_t ticks;
	logic [6:0]  port_pins [3];
	logic        irq_a;
	logic        irq_b;
	logic        irq_c;

	port_bus_if bus_a ();
	port_bus_if bus_b ();
	port_bus_if bus_c ();

	assign port_pins = '{port_a_i, port_b_i, port_c_i};
	assign hl_o = ~(irq_a | irq_b | irq_c); // one shared active-low line.

	io_baud_gen io_baud_gen_inst
	(
		.MCLK    (MCLK),
		.reset_i (reset_i),
		.ticks_o (ticks)
	);

	io_bus io_bus_inst
	(
		.MCLK        (MCLK),
		.reset_i     (reset_i),
		.wr_i        (wr_i),
		.rd_i        (rd_i),
		.addr_i      (addr_i),
		.wdata_i     (wdata_i),
		.ntsc_i      (ntsc_i),
		.disk_i      (disk_i),
		.jap_i       (jap_i),
		.port_pins_i (port_pins),
		.rdata_o     (rdata_o),
		.pa          (bus_a),
		.pb          (bus_b),
		.pc          (bus_c)
	);

	ctrl_port port_a_inst
	(
		.MCLK    (MCLK),
		.reset_i (reset_i),
		.pins_i  (port_a_i),
		.ticks_i (ticks),
		.pins_o  (port_a_o),
		.dir_o   (port_a_dir_o),
		.irq_o   (irq_a),
		.bus     (bus_a)
	);

	ctrl_port port_b_inst
	(
		.MCLK    (MCLK),
		.reset_i (reset_i),
		.pins_i  (port_b_i),
		.ticks_i (ticks),
		.pins_o  (port_b_o),
		.dir_o   (port_b_dir_o),
		.irq_o   (irq_b),
		.bus     (bus_b)
	);

	ctrl_port port_c_inst
	(
		.MCLK    (MCLK),
		.reset_i (reset_i),
		.pins_i  (port_c_i),
		.ticks_i (ticks),
		.pins_o  (port_c_o),
		.dir_o   (port_c_dir_o),
		.irq_o   (irq_c),
		.bus     (bus_c)
	);

endmodule

`default_nettype wire

/* hw/port_bus_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface port_bus_if;
	import io_pkg::*;

	logic [7:0] wdata;
	logic       wr_data;
	logic       wr_ctrl;
	logic       wr_tx;
	logic       wr_sctrl;
	logic       rd_rx; // read of the receive register clears the flags.

	logic [7:0] pdata;
	logic [7:0] pctrl;
	logic [7:0] tx_hold;
	logic [7:0] rx_data;
	sctrl_u     sctrl_status;

	modport bus
	(
		output wdata, wr_data, wr_ctrl, wr_tx, wr_sctrl, rd_rx,
		input  pdata, pctrl, tx_hold, rx_data, sctrl_status
	);

	modport port
	(
		input  wdata, wr_data, wr_ctrl, wr_tx, wr_sctrl, rd_rx,
		output pdata, pctrl, tx_hold, rx_data, sctrl_status
	);

endinterface

`default_nettype wire

/* hw/uart_rx.sv */
`timescale 1ns/100ps
`default_nettype none

`include "io_macros.svh"

module uart_rx
(
	input  wire logic                  MCLK,
	input  wire logic                  reset_i,
	input  wire logic                  tick_i,
	input  wire logic                  enable_i,
	input  wire logic                  line_i,
	input  wire logic                  clear_i,
	output logic [`UART_DATA_BITS-1:0] data_o,
	output logic                       ready_o,
	output logic                       error_o
);

	localparam int OS_W = $clog2(`UART_OVERSAMPLE);
	localparam int FRAME_BITS = `UART_DATA_BITS + 2;
	localparam logic [OS_W-1:0] OS_MID = OS_W'(`UART_OVERSAMPLE / 2 - 1);
	localparam logic [OS_W-1:0] OS_LAST = OS_W'(`UART_OVERSAMPLE - 1);
	localparam logic [3:0] STOP_IDX = 4'(FRAME_BITS - 1);

	logic [2:0]                 sync_q; // two synchronizer stages and one history stage.
	logic                       line_s;
	logic                       fall;
	logic                       active_q;
	logic [OS_W-1:0]            os_cnt_q;
	logic [3:0]                 bit_cnt_q;
	logic [`UART_DATA_BITS-1:0] shift_q;
	logic                       mid_tick;
	logic                       stop_tick;

	assign line_s = sync_q[1];
	assign fall = sync_q[2] & ~sync_q[1];
	assign mid_tick = enable_i & active_q & tick_i & (os_cnt_q == OS_MID);
	assign stop_tick = mid_tick & (bit_cnt_q == STOP_IDX);

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
			sync_q <= 3'b111;
		else
			sync_q <= {sync_q[1:0], line_i};
	end

	always_ff @(posedge MCLK)
	begin
		if (reset_i || !enable_i)
		begin
			active_q <= 1'b0;
			os_cnt_q <= '0;
			bit_cnt_q <= '0;
		end
		else if (!active_q)
		begin
			if (fall)
			begin
				active_q <= 1'b1;
				os_cnt_q <= '0;
				bit_cnt_q <= '0;
			end
		end
		else if (tick_i)
		begin
			if (os_cnt_q == OS_LAST)
			begin
				os_cnt_q <= '0;
				bit_cnt_q <= bit_cnt_q + 4'd1;
			end
			else
				os_cnt_q <= os_cnt_q + 1'b1;
			// a start bit that is high again at mid-bit was a glitch.
			if (stop_tick || (mid_tick && bit_cnt_q == 4'd0 && line_s))
				active_q <= 1'b0;
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (mid_tick && bit_cnt_q != 4'd0 && bit_cnt_q != STOP_IDX)
			shift_q <= {line_s, shift_q[`UART_DATA_BITS-1:1]}; // LSB arrives first.
	end

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			data_o <= '0;
			ready_o <= 1'b0;
			error_o <= 1'b0;
		end
		else if (stop_tick)
		begin
			data_o <= shift_q;
			ready_o <= 1'b1;
			error_o <= ~line_s;
		end
		else if (clear_i)
		begin
			ready_o <= 1'b0;
			error_o <= 1'b0;
		end
	end

	a_ready_enabled: assert property (@(posedge MCLK) disable iff (reset_i)
		$rose(ready_o) |-> $past(enable_i));

endmodule

`default_nettype wire

/* hw/uart_tx.sv */
`timescale 1ns/100ps
`default_nettype none

`include "io_macros.svh"

module uart_tx
(
	input  wire logic                       MCLK,
	input  wire logic                       reset_i,
	input  wire logic                       tick_i,
	input  wire logic                       enable_i,
	input  wire logic                       load_i,
	input  wire logic [`UART_DATA_BITS-1:0] data_i,
	output logic                            line_o,
	output logic                            full_o
);

	localparam int OS_W = $clog2(`UART_OVERSAMPLE);
	localparam int FRAME_BITS = `UART_DATA_BITS + 2;
	localparam logic [OS_W-1:0] OS_LAST = OS_W'(`UART_OVERSAMPLE - 1);
	localparam logic [3:0] STOP_IDX = 4'(FRAME_BITS - 1);

	logic [`UART_DATA_BITS-1:0] hold_q;
	logic [FRAME_BITS-1:0]      shift_q;
	logic                       full_q;
	logic                       busy_q;
	logic [OS_W-1:0]            os_cnt_q;
	logic [3:0]                 bit_cnt_q;
	logic                       start;
	logic                       bit_end;

	assign start = tick_i & full_q & ~busy_q;
	assign bit_end = busy_q & tick_i & (os_cnt_q == OS_LAST);
	assign line_o = busy_q ? shift_q[0] : 1'b1;
	assign full_o = full_q;

	always_ff @(posedge MCLK)
	begin
		if (load_i)
			hold_q <= data_i; // a byte still waiting is simply replaced.
		if (start)
			shift_q <= {1'b1, hold_q, 1'b0};
		else if (bit_end)
			shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
	end

	always_ff @(posedge MCLK)
	begin
		if (reset_i || !enable_i)
		begin
			full_q <= 1'b0;
			busy_q <= 1'b0;
			os_cnt_q <= '0;
			bit_cnt_q <= '0;
		end
		else
		begin
			if (load_i)
				full_q <= 1'b1;
			else if (start)
				full_q <= 1'b0;

			if (start)
			begin
				busy_q <= 1'b1;
				os_cnt_q <= '0;
				bit_cnt_q <= '0;
			end
			else if (busy_q && tick_i)
			begin
				os_cnt_q <= os_cnt_q + 1'b1;
				if (bit_end)
				begin
					os_cnt_q <= '0;
					bit_cnt_q <= bit_cnt_q + 4'd1;
					if (bit_cnt_q == STOP_IDX)
						busy_q <= 1'b0; // stop bit done.
				end
			end
		end
	end

endmodule

`default_nettype wire

/* include/io_macros.svh */
`ifndef IO_MACROS_SVH
`define IO_MACROS_SVH

// register map of port A; ports B and C follow at fixed offsets.
`define IO_ADDR_VERSION 4'd0
`define IO_ADDR_DATA_A  4'd1
`define IO_ADDR_CTRL_A  4'd4
`define IO_ADDR_TX_A    4'd7
`define IO_ADDR_RX_A    4'd8
`define IO_ADDR_SCTRL_A 4'd9

// MCLK cycles per oversample tick at the fastest serial rate.
`define BAUD_BASE_DIV 2

// oversample ticks per serial bit.
`define UART_OVERSAMPLE 16

// data bits in one 8N1 frame.
`define UART_DATA_BITS 8

`endif

/* sim/io_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module io_checker
(
	input  wire logic        MCLK,
	input  wire logic        reset_i,
	input  wire logic        check_i,
	input  wire logic        exp_rdata_en_i,
	input  wire logic [7:0]  exp_rdata_i,
	input  wire logic        exp_hl_en_i,
	input  wire logic        exp_hl_i,
	input  wire logic [1:0]  exp_port_i, // 0 skips the pin check, 1 to 3 select A to C.
	input  wire logic [6:0]  exp_out_i,
	input  wire logic [6:0]  exp_dir_i,
	input  wire logic [7:0]  dut_rdata_i,
	input  wire logic        dut_hl_i,
	input  wire logic [20:0] dut_pins_i,
	input  wire logic [20:0] dut_dirs_i,
	output int               errors_o
);

	int errors_q;

	assign errors_o = errors_q;

	function automatic logic [6:0] pick(input logic [20:0] v, input logic [1:0] p);
		case (p)
			2'd1: return v[6:0];
			2'd2: return v[13:7];
			default: return v[20:14];
		endcase
	endfunction

	always @(posedge MCLK)
	begin : compare
		int n;
		n = 0;
		if (reset_i)
			errors_q <= 0;
		else if (check_i)
		begin
			if (exp_rdata_en_i && dut_rdata_i !== exp_rdata_i)
			begin
				$display("[ERROR] %0t: rdata_o is %h, expected %h", $time, dut_rdata_i,
					exp_rdata_i);
				n++;
			end
			if (exp_hl_en_i && dut_hl_i !== exp_hl_i)
			begin
				$display("[ERROR] %0t: hl_o is %b, expected %b", $time, dut_hl_i, exp_hl_i);
				n++;
			end
			if (exp_port_i != 2'd0 && pick(dut_pins_i, exp_port_i) !== exp_out_i)
			begin
				$display("[ERROR] %0t: port %0d output is %h, expected %h", $time, exp_port_i,
					pick(dut_pins_i, exp_port_i), exp_out_i);
				n++;
			end
			if (exp_port_i != 2'd0 && pick(dut_dirs_i, exp_port_i) !== exp_dir_i)
			begin
				$display("[ERROR] %0t: port %0d direction is %h, expected %h", $time,
					exp_port_i, pick(dut_dirs_i, exp_port_i), exp_dir_i);
				n++;
			end
			errors_q <= errors_q + n;
		end
	end

endmodule

`default_nettype wire

/* sim/tb_md_io.sv */
`timescale 1ns/100ps
`default_nettype none

`include "io_macros.svh"

module tb_clock
(
	output logic clk_o
);

	initial
		clk_o = 1'b0;

	always #10 clk_o = ~clk_o; // 20 ns period.

endmodule

module tb_md_io;

	typedef enum logic [2:0] {OP_WR, OP_RD, OP_PINS, OP_REGION, OP_WAIT, OP_TXR, OP_RDP,
		OP_BANG} op_t;

	typedef struct packed {
		op_t        op;
		logic [3:0] addr;
		logic [7:0] data; // write data, region bits or the poll mask.
		logic [6:0] pins;
		logic       rd_en;
		logic [7:0] rd;
		logic       hl_en;
		logic       hl;
		logic [1:0] port;
		logic [6:0] out;
		logic [6:0] dir;
	} entry_t;

	localparam int BANG_BIT_CYCLES = `UART_OVERSAMPLE * (`BAUD_BASE_DIV << 1);
	localparam longint FRAME_WORST_NS = 10 * `UART_OVERSAMPLE * (`BAUD_BASE_DIV << 3) * 20;
	localparam int POLL_LIMIT = 2000;

	logic        MCLK;
	logic        reset_i;
	logic        wr_i;
	logic        rd_i;
	logic [3:0]  addr_i;
	logic [7:0]  wdata_i;
	logic [7:0]  rdata_o;
	logic        ntsc_i;
	logic        disk_i;
	logic        jap_i;
	logic [6:0]  port_a_i;
	logic [6:0]  port_b_i;
	logic [6:0]  port_c_i;
	logic [6:0]  pins_b;
	logic [6:0]  port_a_o;
	logic [6:0]  port_b_o;
	logic [6:0]  port_c_o;
	logic [6:0]  port_a_dir_o;
	logic [6:0]  port_b_dir_o;
	logic [6:0]  port_c_dir_o;
	logic        hl_o;
	logic        check_q;
	entry_t      exp_q;
	entry_t      tests [$];
	logic [7:0]  sent [$];
	logic [15:0] lfsr_q;
	int          other_fails;
	int          value_errors;
	longint      watchdog_ns = 0;

	assign port_b_i = {pins_b[6], port_a_o[4], pins_b[4:0]}; // A transmit loops to B receive.

	tb_clock tb_clock_inst (.clk_o(MCLK));

	md_io md_io_inst
	(
		.MCLK (MCLK), .reset_i (reset_i), .wr_i (wr_i), .rd_i (rd_i), .addr_i (addr_i),
		.wdata_i (wdata_i), .rdata_o (rdata_o), .ntsc_i (ntsc_i), .disk_i (disk_i),
		.jap_i (jap_i), .port_a_i (port_a_i), .port_a_o (port_a_o), .port_a_dir_o (port_a_dir_o),
		.port_b_i (port_b_i), .port_b_o (port_b_o), .port_b_dir_o (port_b_dir_o),
		.port_c_i (port_c_i), .port_c_o (port_c_o), .port_c_dir_o (port_c_dir_o), .hl_o (hl_o)
	);

	io_checker io_checker_inst
	(
		.MCLK (MCLK), .reset_i (reset_i), .check_i (check_q), .exp_rdata_en_i (exp_q.rd_en),
		.exp_rdata_i (exp_q.rd), .exp_hl_en_i (exp_q.hl_en), .exp_hl_i (exp_q.hl),
		.exp_port_i (exp_q.port), .exp_out_i (exp_q.out), .exp_dir_i (exp_q.dir),
		.dut_rdata_i (rdata_o), .dut_hl_i (hl_o), .dut_pins_i ({port_c_o, port_b_o, port_a_o}),
		.dut_dirs_i ({port_c_dir_o, port_b_dir_o, port_a_dir_o}), .errors_o (value_errors)
	);

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic next_payload(output logic [7:0] b);
		for (int k = 0; k < 8; k++)
		begin
			lfsr_q = lfsr_step(lfsr_q);
			b[k] = lfsr_q[0];
		end
	endtask

	task automatic add_step(input op_t op, input int addr, input int data, input int pins,
		input int rd, input int hl, input int port, input int out, input int dir);
		entry_t e;
		e.op = op;
		e.addr = 4'(addr);
		e.data = 8'(data);
		e.pins = 7'(pins);
		e.rd_en = (rd >= 0);
		e.rd = 8'(rd);
		e.hl_en = (hl >= 0);
		e.hl = 1'(hl);
		e.port = 2'(port);
		e.out = 7'(out);
		e.dir = 7'(dir);
		tests.push_back(e);
	endtask

	task automatic build_table();
		// reset values.
		add_step(OP_RD, 4, 0, 0, 'h00, 1, 1, 'h00, 'h00);
		add_step(OP_RD, 5, 0, 0, 'h00, 1, 2, 'h00, 'h00);
		add_step(OP_RD, 6, 0, 0, 'h00, 1, 3, 'h00, 'h00);
		add_step(OP_RD, 9, 0, 0, 'h00, -1, 0, 0, 0);
		add_step(OP_RD, 12, 0, 0, 'h00, -1, 0, 0, 0);
		add_step(OP_RD, 15, 0, 0, 'h00, -1, 0, 0, 0);
		add_step(OP_RD, 7, 0, 0, 'h00, -1, 0, 0, 0);
		add_step(OP_RD, 10, 0, 0, 'h00, -1, 0, 0, 0);
		add_step(OP_RD, 13, 0, 0, 'h00, -1, 0, 0, 0);
		// the region bits are given as {jap, ntsc, disk} for each version read.
		add_step(OP_REGION, 0, 'h4, 0, -1, -1, 0, 0, 0);
		add_step(OP_RD, 0, 0, 0, 'hC0, -1, 0, 0, 0);
		add_step(OP_REGION, 0, 'h3, 0, -1, -1, 0, 0, 0);
		add_step(OP_RD, 0, 0, 0, 'h20, -1, 0, 0, 0);
		add_step(OP_REGION, 0, 'h1, 0, -1, -1, 0, 0, 0);
		add_step(OP_RD, 0, 0, 0, 'h60, -1, 0, 0, 0);
		// parallel registers on ports A and C.
		add_step(OP_WR, 1, 'hA5, 0, -1, 1, 1, 'h25, 'h00);
		add_step(OP_WR, 4, 'h3C, 0, -1, 1, 1, 'h25, 'h3C);
		add_step(OP_PINS, 0, 0, 'h5A, -1, 1, 0, 0, 0);
		add_step(OP_RD, 1, 0, 0, 'hDA, -1, 1, 'h25, 'h3C);
		add_step(OP_WR, 3, 'h7E, 0, -1, 1, 3, 'h7E, 'h00);
		add_step(OP_WR, 6, 'h41, 0, -1, 1, 3, 'h7E, 'h41);
		add_step(OP_RD, 3, 0, 0, 'h20, -1, 0, 0, 0);
		// TH interrupt on port B.
		add_step(OP_PINS, 1, 0, 'h00, -1, 1, 0, 0, 0);
		add_step(OP_WR, 5, 'h80, 0, -1, 0, 2, 'h00, 'h00);
		add_step(OP_PINS, 1, 0, 'h40, -1, 1, 0, 0, 0);
		add_step(OP_PINS, 1, 0, 'h00, -1, 0, 0, 0, 0);
		add_step(OP_WR, 5, 'h00, 0, -1, 1, 2, 'h00, 'h00);
		// loopback from A to B at baud_sel 0 while the second byte waits in the holding register.
		add_step(OP_WR, 9, 'h10, 0, -1, 1, 1, 'h35, 'h3C);
		add_step(OP_WR, 12, 'h28, 0, -1, 1, 2, 'h00, 'h00);
		add_step(OP_TXR, 7, 0, 0, -1, -1, 0, 0, 0);
		add_step(OP_TXR, 7, 0, 0, -1, -1, 0, 0, 0);
		add_step(OP_RD, 9, 0, 0, 'h11, -1, 0, 0, 0);
		add_step(OP_WAIT, 12, 'h02, 0, 'h2A, 0, 0, 0, 0);
		add_step(OP_RDP, 11, 0, 0, -1, 1, 0, 0, 0);
		add_step(OP_RD, 12, 0, 0, 'h28, 1, 0, 0, 0);
		add_step(OP_WAIT, 12, 'h02, 0, 'h2A, 0, 0, 0, 0);
		add_step(OP_RDP, 11, 0, 0, -1, 1, 0, 0, 0);
		add_step(OP_RD, 9, 0, 0, 'h10, 1, 0, 0, 0);
		// framing error on port C at baud_sel 1.
		add_step(OP_WR, 15, 'h60, 0, -1, 1, 3, 'h7E, 'h41);
		add_step(OP_BANG, 0, 0, 0, -1, -1, 0, 0, 0);
		add_step(OP_WAIT, 15, 'h02, 0, 'h66, 1, 0, 0, 0);
		add_step(OP_RDP, 14, 0, 0, -1, 1, 0, 0, 0);
		add_step(OP_RD, 15, 0, 0, 'h60, 1, 0, 0, 0);
	endtask

	task automatic set_pins(input logic [3:0] port, input logic [6:0] v);
		case (port)
			4'd0: port_a_i = v;
			4'd1: pins_b = v;
			default: port_c_i = v;
		endcase
	endtask

	task automatic wait_flag(input logic [3:0] addr, input logic [7:0] mask,
		input logic [7:0] want);
		int polls;
		logic hit;
		polls = 0;
		hit = 1'b0;
		while (!hit && polls < POLL_LIMIT)
		begin
			addr_i = addr;
			rd_i = 1'b1;
			@(posedge MCLK);
			#2;
			rd_i = 1'b0;
			hit = ((rdata_o & mask) == (want & mask));
			polls++;
		end
		if (!hit)
		begin
			other_fails++;
			$display("status register %0d did not show the awaited flag within %0d polls",
				addr, POLL_LIMIT);
		end
	endtask

	task automatic send_frame(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b0, b, 1'b0}; // the stop bit is 0, so the frame is malformed.
		for (int k = 0; k < 10; k++)
		begin
			port_c_i[5] = frame[k];
			repeat (BANG_BIT_CYCLES) @(posedge MCLK);
			#2;
		end
		port_c_i[5] = 1'b1;
	endtask

	initial
	begin
		entry_t e;
		logic [7:0] b;
		reset_i = 1'b1;
		wr_i = 1'b0;
		rd_i = 1'b0;
		addr_i = 4'd0;
		wdata_i = 8'h00;
		{jap_i, ntsc_i, disk_i} = 3'b010;
		port_a_i = 7'h00;
		pins_b = 7'h00;
		port_c_i = 7'h20; // receive pin of C idles high.
		check_q = 1'b0;
		exp_q = '0;
		lfsr_q = 16'd15618;
		other_fails = 0;
		build_table();
		watchdog_ns = longint'(tests.size()) * FRAME_WORST_NS + 100000;
		repeat (4) @(posedge MCLK);
		#2;
		reset_i = 1'b0;
		foreach (tests[i])
		begin
			e = tests[i];
			@(posedge MCLK);
			#2;
			case (e.op)
				OP_WR:
				begin
					addr_i = e.addr;
					wdata_i = e.data;
					wr_i = 1'b1;
				end
				OP_RD:
				begin
					addr_i = e.addr;
					rd_i = 1'b1;
				end
				OP_PINS: set_pins(e.addr, e.pins);
				OP_REGION: {jap_i, ntsc_i, disk_i} = e.data[2:0];
				OP_WAIT: wait_flag(e.addr, e.data, e.rd);
				OP_TXR:
				begin
					next_payload(b);
					sent.push_back(b);
					addr_i = e.addr;
					wdata_i = b;
					wr_i = 1'b1;
				end
				OP_RDP:
				begin
					b = sent.pop_front();
					e.rd_en = 1'b1;
					e.rd = b; // oldest byte sent is the next one received.
					addr_i = e.addr;
					rd_i = 1'b1;
				end
				default:
				begin
					next_payload(b);
					sent.push_back(b);
					send_frame(b);
				end
			endcase
			@(posedge MCLK);
			#2;
			wr_i = 1'b0;
			rd_i = 1'b0;
			exp_q = e;
			check_q = 1'b1;
			@(posedge MCLK);
			#2;
			check_q = 1'b0;
		end
		repeat (2) @(posedge MCLK);
		$display("checks finished with %0d value errors and %0d other failures",
			value_errors, other_fails);
		if (value_errors == 0 && other_fails == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		wait (watchdog_ns != 0);
		#(watchdog_ns);
		$display("watchdog expired after %0d ns before the stimulus table finished",
			watchdog_ns);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
